// ==== hdl/cache_consts.svh ====
// Cache geometry constants.
// Direct-mapped data cache with 64 lines of four 32-bit words each.
// Address split is tag | index | word offset | byte offset.

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte address and data word
`define CACHE_ADDR_BITS   32
`define CACHE_DATA_BITS   32

// line index, 64 lines
`define CACHE_INDEX_BITS  6

// word within a line, four words
`define CACHE_OFFSET_BITS 2

// byte within a word
`define CACHE_BYTE_BITS   2

// also the number of cycles spent clearing lines after reset
`define CACHE_LINES       (1 << `CACHE_INDEX_BITS)

`endif

// ==== hdl/cache_pkg.sv ====
// Cache types.
// Address, data and line vectors, memory message codes, the controller
// state encoding and the request and response bundles.

`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0]     addr_t;
    typedef logic [`CACHE_DATA_BITS-1:0]     word_t;
    typedef logic [`CACHE_DATA_BITS/8-1:0]   byte_en_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]    index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0]   offset_t;
    typedef logic [(`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS
                    - `CACHE_BYTE_BITS)-1:0] tag_t;
    typedef logic [`CACHE_DATA_BITS*(1 << `CACHE_OFFSET_BITS)-1:0] line_t;

    typedef enum logic [1:0] {
        NO_REQ,
        R_REQ,
        WB_REQ,
        MEM_RESP
    } mem_msg_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        ACCESS,
        WRITE_BACK,
        WB_WAIT,
        READ_REQ,
        READ_WAIT,
        UPDATE
    } ctrl_state_t;

    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    addr;
        word_t    data;
        byte_en_t byte_en;
    } cpu_req_t;

    // line-aligned address, data only used by write-back
    typedef struct packed {
        mem_msg_t msg;
        addr_t    addr;
        line_t    data;
    } mem_req_t;

    typedef struct packed {
        mem_msg_t msg;
        line_t    data;
    } mem_resp_t;

endpackage

// ==== hdl/cache_store.sv ====
// Line store for the direct-mapped cache.
// Tag, valid, dirty and data arrays with a registered read port.
// Hit is the registered tag and valid bit compared with the registered
// lookup tag. One write port serves fills, write hits and the reset sweep.

`include "cache_consts.svh"

module cache_store (
    input  logic              clock,
    input  cache_pkg::index_t lookup_index,
    input  cache_pkg::tag_t   lookup_tag,
    input  logic              store_we,
    input  cache_pkg::index_t store_index,
    input  cache_pkg::line_t  store_line,
    input  logic              store_dirty,
    input  logic              store_valid,
    output logic              hit,
    output cache_pkg::tag_t   victim_tag,
    output logic              victim_dirty,
    output cache_pkg::line_t  line_rd
);
    import cache_pkg::*;

    tag_t                    tag_mem [`CACHE_LINES];
    line_t                   line_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_mem;
    logic [`CACHE_LINES-1:0] dirty_mem;

    tag_t                    lookup_tag_q;
    logic                    valid_q;

    // writes take the tag of the line last looked up, which is the
    // controller's held request whenever a write is issued
    always_ff @(posedge clock) begin
        if (store_we) begin
            tag_mem[store_index]   <= lookup_tag_q;
            line_mem[store_index]  <= store_line;
            valid_mem[store_index] <= store_valid;
            dirty_mem[store_index] <= store_dirty;
        end
    end

    // read one cycle after lookup
    always_ff @(posedge clock) begin
        victim_tag   <= tag_mem[lookup_index];
        line_rd      <= line_mem[lookup_index];
        valid_q      <= valid_mem[lookup_index];
        victim_dirty <= dirty_mem[lookup_index];
        lookup_tag_q <= lookup_tag;
    end

    assign hit = valid_q & (victim_tag == lookup_tag_q);

endmodule

// ==== hdl/mem_port.sv ====
// Memory message port.
// Registers an outbound request on the start strobe and holds it until
// memory answers with MEM_RESP. Signals completion in the response cycle
// and keeps the returned line for the controller's fill.

module mem_port (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 mem_start,
    input  cache_pkg::mem_msg_t  mem_msg,
    input  cache_pkg::addr_t     mem_addr,
    input  cache_pkg::line_t     mem_line,
    input  cache_pkg::mem_resp_t mem_resp,
    output cache_pkg::mem_req_t  mem_req,
    output logic                 mem_done,
    output cache_pkg::line_t     fill_line
);
    import cache_pkg::*;

    mem_msg_t msg_q;
    addr_t    addr_q;
    line_t    line_q;

    assign mem_done = (msg_q != NO_REQ) & (mem_resp.msg == MEM_RESP);

    // message held until answered
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            msg_q <= NO_REQ;
        end else if (mem_done) begin
            msg_q <= NO_REQ;
        end else if (mem_start) begin
            msg_q <= mem_msg;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_start) begin
            addr_q <= mem_addr;
            line_q <= mem_line;
        end
    end

    // only meaningful after an R_REQ
    always_ff @(posedge clock) begin
        if (mem_done) begin
            fill_line <= mem_resp.data;
        end
    end

    assign mem_req.msg  = msg_q;
    assign mem_req.addr = addr_q;
    assign mem_req.data = line_q;

endmodule

// ==== hdl/cache_fsm.sv ====
// Cache controller FSM.
// Latches processor requests, clears the store after reset, answers hits
// in one cycle and handles misses with an optional write-back of a dirty
// victim followed by a line fill. Write data is byte-merged into the line
// read on a hit or into the fill line on a miss.

`include "cache_consts.svh"

module cache_fsm (
    input  logic                clock,
    input  logic                rst_n,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                hit,
    input  cache_pkg::tag_t     victim_tag,
    input  logic                victim_dirty,
    input  cache_pkg::line_t    line_rd,
    input  logic                mem_done,
    input  cache_pkg::line_t    fill_line,
    output logic                ready,
    output logic                valid,
    output cache_pkg::word_t    data_out,
    output cache_pkg::addr_t    out_address,
    output cache_pkg::index_t   lookup_index,
    output cache_pkg::tag_t     lookup_tag,
    output logic                store_we,
    output cache_pkg::index_t   store_index,
    output cache_pkg::line_t    store_line,
    output logic                store_dirty,
    output logic                store_valid,
    output logic                mem_start,
    output cache_pkg::mem_msg_t mem_msg,
    output cache_pkg::addr_t    mem_addr,
    output cache_pkg::line_t    mem_line
);
    import cache_pkg::*;

    localparam int IDX_LSB = `CACHE_OFFSET_BITS + `CACHE_BYTE_BITS;
    localparam int TAG_LSB = IDX_LSB + `CACHE_INDEX_BITS;

    ctrl_state_t state;
    ctrl_state_t next_state;
    cpu_req_t    req_q;
    index_t      sweep_cnt;
    logic        accept;
    logic        write_hit;
    index_t      in_index;
    index_t      req_index;
    tag_t        in_tag;
    tag_t        req_tag;
    offset_t     req_offset;
    line_t       base_line;

    function automatic line_t merge_word(
        input line_t    base,
        input offset_t  off,
        input word_t    data,
        input byte_en_t be
    );
        line_t merged;
        int    b;
        merged = base;
        for (b = 0; b < `CACHE_DATA_BITS / 8; b++) begin
            if (be[b]) begin
                merged[off * `CACHE_DATA_BITS + b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

    assign in_index   = cpu_req.addr[IDX_LSB +: `CACHE_INDEX_BITS];
    assign in_tag     = cpu_req.addr[`CACHE_ADDR_BITS-1:TAG_LSB];
    assign req_index  = req_q.addr[IDX_LSB +: `CACHE_INDEX_BITS];
    assign req_tag    = req_q.addr[`CACHE_ADDR_BITS-1:TAG_LSB];
    assign req_offset = req_q.addr[`CACHE_BYTE_BITS +: `CACHE_OFFSET_BITS];

    // a held write blocks a new request to the same line for one cycle
    assign ready = (state == IDLE) |
                   ((state == ACCESS) & hit & ~(req_q.write & (in_index == req_index)));
    assign accept    = ready & (cpu_req.read | cpu_req.write);
    assign write_hit = (state == ACCESS) & hit & req_q.write;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= SWEEP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SWEEP: begin
                if (sweep_cnt == index_t'(`CACHE_LINES - 1)) begin
                    next_state = IDLE;
                end
            end
            IDLE: begin
                if (accept) begin
                    next_state = ACCESS;
                end
            end
            ACCESS: begin
                if (hit) begin
                    next_state = accept ? ACCESS : IDLE;
                end else begin
                    next_state = victim_dirty ? WRITE_BACK : READ_REQ;
                end
            end
            WRITE_BACK: next_state = WB_WAIT;
            WB_WAIT: begin
                if (mem_done) begin
                    next_state = READ_REQ;
                end
            end
            READ_REQ: next_state = READ_WAIT;
            READ_WAIT: begin
                if (mem_done) begin
                    next_state = UPDATE;
                end
            end
            UPDATE: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_q.read  <= 1'b0;
            req_q.write <= 1'b0;
        end else if (accept) begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sweep_cnt <= '0;
        end else if (state == SWEEP) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    // new request looks up on the accepting edge, else keep the held one
    assign lookup_index = accept ? in_index : req_index;
    assign lookup_tag   = accept ? in_tag : req_tag;

    assign base_line   = (state == UPDATE) ? fill_line : line_rd;
    assign store_we    = (state == SWEEP) | (state == UPDATE) | write_hit;
    assign store_index = (state == SWEEP) ? sweep_cnt : req_index;
    assign store_line  = req_q.write ?
                         merge_word(base_line, req_offset, req_q.data, req_q.byte_en) :
                         base_line;
    assign store_dirty = (state != SWEEP) & req_q.write;
    assign store_valid = (state != SWEEP);

    assign valid       = (((state == ACCESS) & hit) | (state == UPDATE)) & req_q.read;
    assign data_out    = base_line[req_offset * `CACHE_DATA_BITS +: `CACHE_DATA_BITS];
    assign out_address = req_q.addr;

    // write-back goes to the victim's line, the fill to the request's line
    assign mem_start = (state == WRITE_BACK) | (state == READ_REQ);
    assign mem_msg   = (state == WRITE_BACK) ? WB_REQ : R_REQ;
    assign mem_addr  = (state == WRITE_BACK) ?
                       {victim_tag, req_index, {IDX_LSB{1'b0}}} :
                       {req_tag, req_index, {IDX_LSB{1'b0}}};
    assign mem_line  = (state == WRITE_BACK) ? line_rd : '0;

endmodule

// ==== hdl/cache_top.sv ====
// Direct-mapped write-back data cache.
// Controller FSM, line store and memory message port under one top.

module cache_top (
    input  logic                 clock,
    input  logic                 rst_n,
    input  cache_pkg::cpu_req_t  cpu_req,
    output logic                 ready,
    output logic                 valid,
    output cache_pkg::word_t     data_out,
    output cache_pkg::addr_t     out_address,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_resp_t mem_resp
);
    import cache_pkg::*;

    // store command and status
    index_t   lookup_index;
    tag_t     lookup_tag;
    logic     store_we;
    index_t   store_index;
    line_t    store_line;
    logic     store_dirty;
    logic     store_valid;
    logic     hit;
    tag_t     victim_tag;
    logic     victim_dirty;
    line_t    line_rd;

    // memory port handshake
    logic     mem_start;
    mem_msg_t mem_msg;
    addr_t    mem_addr;
    line_t    mem_line;
    logic     mem_done;
    line_t    fill_line;

    cache_fsm u_fsm (
        .clock        (clock),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .line_rd      (line_rd),
        .mem_done     (mem_done),
        .fill_line    (fill_line),
        .ready        (ready),
        .valid        (valid),
        .data_out     (data_out),
        .out_address  (out_address),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .store_we     (store_we),
        .store_index  (store_index),
        .store_line   (store_line),
        .store_dirty  (store_dirty),
        .store_valid  (store_valid),
        .mem_start    (mem_start),
        .mem_msg      (mem_msg),
        .mem_addr     (mem_addr),
        .mem_line     (mem_line)
    );

    cache_store u_store (
        .clock        (clock),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .store_we     (store_we),
        .store_index  (store_index),
        .store_line   (store_line),
        .store_dirty  (store_dirty),
        .store_valid  (store_valid),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .line_rd      (line_rd)
    );

    mem_port u_mem_port (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_start (mem_start),
        .mem_msg   (mem_msg),
        .mem_addr  (mem_addr),
        .mem_line  (mem_line),
        .mem_resp  (mem_resp),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .fill_line (fill_line)
    );

endmodule

// ==== sim/cache_asserts.sv ====
// Protocol assertions for the cache top level.
// Checks quiet valid during reset and sweep, held memory requests and
// line-aligned memory addresses.

`include "cache_consts.svh"

module cache_asserts (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 ready,
    input logic                 valid,
    input cache_pkg::mem_req_t  mem_req,
    input cache_pkg::mem_resp_t mem_resp
);
    import cache_pkg::*;

    // set once the sweep has finished
    logic seen_ready;

    // number of assertion failures so far
    int   fail_count = 0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            seen_ready <= 1'b0;
        end else if (ready) begin
            seen_ready <= 1'b1;
        end
    end

    no_valid_in_reset: assert property (@(posedge clock) !rst_n |-> !valid)
        else begin
            $error("valid high during reset");
            fail_count++;
        end

    no_valid_in_sweep: assert property (@(posedge clock) (rst_n && !seen_ready) |-> !valid)
        else begin
            $error("valid high during sweep");
            fail_count++;
        end

    req_held: assert property (@(posedge clock) disable iff (!rst_n)
        (mem_req.msg != NO_REQ && mem_resp.msg != MEM_RESP) |=> $stable(mem_req))
        else begin
            $error("memory request changed before response");
            fail_count++;
        end

    req_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        (mem_req.msg != NO_REQ) |->
        (mem_req.addr[`CACHE_OFFSET_BITS + `CACHE_BYTE_BITS - 1:0] == '0))
        else begin
            $error("memory request address not line-aligned");
            fail_count++;
        end

endmodule

bind cache_top cache_asserts u_asserts (
    .clock    (clock),
    .rst_n    (rst_n),
    .ready    (ready),
    .valid    (valid),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
);

// ==== sim/tb_cache.sv ====
// Testbench for the direct-mapped cache.
// Reads requests from a vector file, models memory with random response
// delay and checks read data, hit timing and memory traffic against a
// flat reference memory and a tag model.

`include "cache_consts.svh"

module tb_cache;
    import cache_pkg::*;

    localparam int IDX_LSB = `CACHE_OFFSET_BITS + `CACHE_BYTE_BITS;
    localparam int TAG_LSB = IDX_LSB + `CACHE_INDEX_BITS;
    localparam int LINE_BYTES = 1 << IDX_LSB;
    localparam int WAIT_LIMIT = 400;

    logic      clock;
    logic      rst_n;
    cpu_req_t  cpu_req;
    logic      ready;
    logic      valid;
    word_t     data_out;
    addr_t     out_address;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    integer seed = 261;
    int     cycle = 0;
    int     data_errors = 0;
    int     mem_errors = 0;
    int     proto_errors = 0;

    logic [7:0] ref_mem [addr_t];
    logic [7:0] mem_bytes [addr_t];
    tag_t                    tag_model [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_model = '0;
    logic [`CACHE_LINES-1:0] dirty_model = '0;

    // previous accepted request, decides whether the next one must be taken at once
    bit     last_hit = 0;
    bit     last_write = 0;
    index_t last_index = '0;

    // expected read results and memory messages in issue order
    word_t    exp_word_q [$];
    addr_t    exp_raddr_q [$];
    int       exp_cycle_q [$];
    bit       exp_hit_q [$];
    mem_msg_t exp_msg_q [$];
    addr_t    exp_addr_q [$];

    cache_top uut (
        .clock       (clock),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .ready       (ready),
        .valid       (valid),
        .data_out    (data_out),
        .out_address (out_address),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // untouched memory holds a pattern folded from every address bit
    function automatic logic [7:0] fill_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic line_t ref_line(input addr_t base);
        line_t l;
        addr_t a;
        for (int k = 0; k < LINE_BYTES; k++) begin
            a = base + addr_t'(k);
            l[k*8 +: 8] = ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
        end
        return l;
    endfunction

    function automatic line_t mem_line(input addr_t base);
        line_t l;
        addr_t a;
        for (int k = 0; k < LINE_BYTES; k++) begin
            a = base + addr_t'(k);
            l[k*8 +: 8] = mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
        end
        return l;
    endfunction

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Testbench failed");
        $finish;
    endtask

    // update tag model and reference memory for an accepted request
    task automatic note_accept(input cpu_req_t r);
        index_t idx;
        tag_t   tg;
        addr_t  waddr;
        bit     hit;
        line_t  ln;
        idx = r.addr[IDX_LSB +: `CACHE_INDEX_BITS];
        tg = r.addr[`CACHE_ADDR_BITS-1:TAG_LSB];
        waddr = {r.addr[`CACHE_ADDR_BITS-1:`CACHE_BYTE_BITS], 2'b00};
        hit = valid_model[idx] && (tag_model[idx] == tg);
        if (!hit) begin
            if (valid_model[idx] && dirty_model[idx]) begin
                exp_msg_q.push_back(WB_REQ);
                exp_addr_q.push_back({tag_model[idx], idx, 4'b0000});
            end
            exp_msg_q.push_back(R_REQ);
            exp_addr_q.push_back({tg, idx, 4'b0000});
            valid_model[idx] = 1'b1;
            dirty_model[idx] = 1'b0;
            tag_model[idx] = tg;
        end
        if (r.write) begin
            for (int b = 0; b < 4; b++) begin
                if (r.byte_en[b]) begin
                    ref_mem[waddr + addr_t'(b)] = r.data[b*8 +: 8];
                end
            end
            dirty_model[idx] = 1'b1;
        end else begin
            ln = ref_line({waddr[31:4], 4'b0000});
            exp_word_q.push_back(ln[waddr[3:2]*32 +: 32]);
            exp_raddr_q.push_back(r.addr);
            exp_cycle_q.push_back(cycle);
            exp_hit_q.push_back(hit);
        end
        last_hit = hit;
        last_write = r.write;
        last_index = idx;
    endtask

    task automatic issue_request(input cpu_req_t r);
        int     tries;
        bit     back_to_back;
        index_t idx;
        tries = 0;
        idx = r.addr[IDX_LSB +: `CACHE_INDEX_BITS];
        back_to_back = last_hit && (r.read || r.write) &&
                       !(last_write && (idx == last_index));
        cpu_req = r;
        while (1) begin
            @(negedge clock);
            if (tries == 0 && back_to_back && !ready) begin
                $display("[ERROR] %0t request %h not taken in the cycle after a hit",
                         $time, r.addr);
                proto_errors++;
            end
            if (ready) begin
                break;
            end
            tries++;
            if (tries > WAIT_LIMIT) begin
                abort_run("timed out waiting for ready to take a request");
            end
        end
        note_accept(r);
        @(posedge clock);
        #1;
        cpu_req.read = 1'b0;
        cpu_req.write = 1'b0;
    endtask

    // compare each valid pulse with the oldest expected read
    always @(negedge clock) begin
        word_t w;
        addr_t a;
        int    c;
        bit    h;
        if (rst_n && valid) begin
            if (exp_word_q.size() == 0) begin
                $display("valid pulse with no read outstanding at time %0t", $time);
                proto_errors++;
            end else begin
                w = exp_word_q.pop_front();
                a = exp_raddr_q.pop_front();
                c = exp_cycle_q.pop_front();
                h = exp_hit_q.pop_front();
                if (data_out !== w || out_address !== a) begin
                    $display("[ERROR] %0t read %h gave %h at %h, expected %h", $time, a,
                             data_out, out_address, w);
                    data_errors++;
                end
                if (h && cycle != c + 1) begin
                    $display("[ERROR] %0t read hit %h took %0d cycles", $time, a, cycle - c);
                    proto_errors++;
                end
            end
        end
    end

    // memory model answers each message after 0 to 7 cycles
    bit resp_on = 0;
    bit busy = 0;
    int wait_left = 0;
    always @(posedge clock) begin
        mem_msg_t m;
        addr_t    ea;
        #1;
        if (resp_on) begin
            mem_resp.msg = NO_REQ;
            resp_on = 0;
        end else if (rst_n && mem_req.msg != NO_REQ) begin
            if (!busy) begin
                busy = 1;
                wait_left = $random(seed) & 7;
                if (exp_msg_q.size() == 0) begin
                    $display("unexpected memory message at time %0t", $time);
                    proto_errors++;
                end else begin
                    m = exp_msg_q.pop_front();
                    ea = exp_addr_q.pop_front();
                    if (mem_req.msg != m || mem_req.addr !== ea) begin
                        $display("[ERROR] %0t memory message %s %h, expected %s %h", $time,
                                 mem_req.msg.name(), mem_req.addr, m.name(), ea);
                        mem_errors++;
                    end
                end
                if (mem_req.msg == WB_REQ) begin
                    if (mem_req.data !== ref_line(mem_req.addr)) begin
                        $display("[ERROR] %0t write-back data wrong for line %h", $time,
                                 mem_req.addr);
                        mem_errors++;
                    end
                    for (int k = 0; k < LINE_BYTES; k++) begin
                        mem_bytes[mem_req.addr + addr_t'(k)] = mem_req.data[k*8 +: 8];
                    end
                end
            end
            if (wait_left == 0) begin
                mem_resp.msg = MEM_RESP;
                mem_resp.data = mem_line(mem_req.addr);
                resp_on = 1;
                busy = 0;
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        int      fd;
        int      n;
        int      tries;
        string   line_str;
        logic [7:0] op;
        addr_t    a;
        word_t    d;
        byte_en_t be;
        cpu_req_t r;
        clock = 1'b0;
        rst_n = 1'b0;
        cpu_req = '0;
        mem_resp = '0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // sweep keeps ready low for the whole store
        tries = 0;
        while (1) begin
            @(negedge clock);
            if (ready) begin
                break;
            end
            tries++;
            if (tries > WAIT_LIMIT) begin
                abort_run("timed out waiting for ready after reset");
            end
        end
        if (tries < `CACHE_LINES) begin
            $display("[ERROR] %0t ready rose after only %0d cycles", $time, tries);
            proto_errors++;
        end
        @(posedge clock);
        #1;

        fd = $fopen("sim/cache_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the vector file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line_str, fd);
                if (n > 1 && line_str[0] != "#") begin
                    n = $sscanf(line_str, "%c %h %h %h", op, a, d, be);
                    if (n == 4) begin
                        r.read = (op == "R");
                        r.write = (op == "W");
                        r.addr = a;
                        r.data = d;
                        r.byte_en = be;
                        issue_request(r);
                    end
                end
            end
            $fclose(fd);
        end

        // drain outstanding reads and memory messages
        tries = 0;
        while (exp_word_q.size() != 0 || exp_msg_q.size() != 0 || !ready) begin
            @(negedge clock);
            tries++;
            if (tries > WAIT_LIMIT) begin
                abort_run("timed out waiting for outstanding requests to finish");
            end
        end

        $display("errors: data %0d, memory %0d, protocol %0d, assertion %0d",
                 data_errors, mem_errors, proto_errors, uut.u_asserts.fail_count);
        if (data_errors + mem_errors + proto_errors + uut.u_asserts.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sim/cache_vectors.txt ====
# op addr data byte_en, all hex; R ignores data and byte_en
# op is R for read or W for write
W 00000104 11223344 f
R 00000104 00000000 0
R 00000100 00000000 0
W 00000108 aabbccdd 5
R 00000108 00000000 0
R 00000200 00000000 0
R 00000204 00000000 0
R 00000104 00000000 0
R 00000208 00000000 0
R 00000100 00000000 0
R 00000504 00000000 0
R 00000104 00000000 0
W 00000300 12345678 3
W 00000300 ffffffff 8
R 00000300 00000000 0
R 00000700 00000000 0
R 00000300 00000000 0
R 0000c00c 00000000 0
R 0000c008 00000000 0
W 0000c004 0000beef 3
R 0000c004 00000000 0
R 0000000c 00000000 0
R fffffff0 00000000 0
R fffffff4 00000000 0
R 0000c004 00000000 0

// ==== verilog.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/mem_port.sv
hdl/cache_fsm.sv
hdl/cache_top.sv
sim/cache_asserts.sv
sim/tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache -f verilog.f -o sim_cache \
    && ./obj_dir/sim_cache > sim.log 2>&1 \
    || echo "build or simulation did not complete"

grep -q "Testbench passed" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
